/* include/vmu_cfg.svh */
// Vector load subsystem configuration
// Row geometry, register count, bus widths and queue depth
`ifndef VMU_CFG_SVH
`define VMU_CFG_SVH

// Elements per row, one row fills one vector register
`define VMU_LANES   4

// Architectural vector registers
`define VMU_VREGS   8

`define VMU_DATA_W  32  // Element width in bits
`define VMU_ADDR_W  32  // Byte address width

// Entries in the decode and writeback queues
`define VMU_QDEPTH  2

`endif

/* verilog/vmu_pkg.sv */
// Vector load subsystem types
// Memory-op encoding and the structs passed between the stages
`default_nettype none

`include "vmu_cfg.svh"

package vmu_pkg;

    // Derived widths
    localparam int LANE_W = $clog2(`VMU_LANES);                 // Lane index / ticket
    localparam int REG_W  = $clog2(`VMU_VREGS);                 // Vector register index
    localparam int VL_W   = $clog2(`VMU_LANES * `VMU_VREGS) + 1; // vl and maxvl, 0..32
    localparam int ROWS_W = $clog2(`VMU_VREGS) + 1;             // Rows per load, 0..8

    // Memory operation field, code 2'b11 is reserved
    typedef enum logic [1:0] {
        OP_UNIT_STRIDED = 2'b00,
        OP_INDEXED      = 2'b01,
        OP_STRIDED      = 2'b10
    } mem_op_e;

    // Remapped vector memory instruction
    typedef struct packed {
        logic                   reconfigure; // Update maxvl, no memory access
        mem_op_e                mem_op;
        logic [REG_W-1:0]       dst;         // First destination register
        logic [`VMU_ADDR_W-1:0] data1;       // Base address
        logic [`VMU_ADDR_W-1:0] data2;       // Stride in bytes
        logic [VL_W-1:0]        vl;
        logic [VL_W-1:0]        maxvl;
    } vmu_instr_t;

    // Decoded load handed to the engine
    typedef struct packed {
        mem_op_e                mem_op;
        logic [REG_W-1:0]       dst;
        logic [`VMU_ADDR_W-1:0] base;
        logic [`VMU_ADDR_W-1:0] stride;
        logic [VL_W-1:0]        vl;    // Already clamped to maxvl
        logic [ROWS_W-1:0]      rows;  // Destination registers to fill
    } vmu_ld_cmd_t;

    // One-element memory request, ticket is the lane
    typedef struct packed {
        logic [`VMU_ADDR_W-1:0] addr;
        logic [LANE_W-1:0]      ticket;
    } mem_req_t;

    typedef struct packed {
        logic [LANE_W-1:0]      ticket;
        logic [`VMU_DATA_W-1:0] data;
    } mem_resp_t;

    // Register file write of one row
    typedef struct packed {
        logic [REG_W-1:0]                        vreg;
        logic [`VMU_LANES-1:0]                   en;   // Lane write enables
        logic [`VMU_LANES-1:0][`VMU_DATA_W-1:0]  data;
    } vmu_wb_t;

endpackage

`default_nettype wire

/* verilog/vmu_fifo.sv */
// Small valid/ready queue with a generic payload
// Registered output with a push accepted whenever not full
`timescale 1ns/100ps
`default_nettype none

`include "vmu_cfg.svh"

module vmu_fifo #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic in_valid_i,
    input  T     in_i,
    output logic in_ready_o,   // Not full
    output logic out_valid_o,  // Not empty
    output T     out_o,
    input  logic out_ready_i
);

    localparam int DEPTH = `VMU_QDEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];  // Entry storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_o       = mem_q[rd_ptr_q];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    //========================================
    // Pointers and fill level
    //========================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem_q[wr_ptr_q] <= in_i;  // Visible from next cycle
    end

endmodule

`default_nettype wire

/* verilog/vmu_ld_decode.sv */
// Vector load decode stage
// Keeps maxvl, drops illegal memory ops, clamps vl and queues load commands
`timescale 1ns/100ps
`default_nettype none

`include "vmu_cfg.svh"

module vmu_ld_decode (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 instr_valid_i,
    input  vmu_pkg::vmu_instr_t  instr_i,
    output logic                 instr_ready_o,
    output logic                 cmd_valid_o,
    output vmu_pkg::vmu_ld_cmd_t cmd_o,
    input  logic                 cmd_ready_i,
    output logic                 illegal_o      // One-cycle pulse after an illegal op
);
    import vmu_pkg::*;

    logic [VL_W-1:0]   maxvl_q;
    logic              illegal_q;
    logic              accept;
    logic              legal;
    logic              is_load;
    logic [VL_W-1:0]   vl_clamp;
    logic [VL_W:0]     vl_round;   // One extra bit for the round-up
    vmu_ld_cmd_t       cmd;

    assign accept  = instr_valid_i & instr_ready_o;
    assign is_load = ~instr_i.reconfigure;

    // Only unit-strided and strided loads are handled
    always_comb begin
        case (instr_i.mem_op)
            OP_UNIT_STRIDED: legal = 1'b1;
            OP_STRIDED:      legal = 1'b1;
            OP_INDEXED:      legal = 1'b0;  // Not supported
            default:         legal = 1'b0;  // Reserved code
        endcase
    end

    //========================================
    // Command build
    //========================================
    assign vl_clamp = (instr_i.vl > maxvl_q) ? maxvl_q : instr_i.vl;
    assign vl_round = {1'b0, vl_clamp} + (VL_W + 1)'(`VMU_LANES - 1);

    always_comb begin
        cmd.mem_op = instr_i.mem_op;
        cmd.dst    = instr_i.dst;
        cmd.base   = instr_i.data1;
        cmd.stride = instr_i.data2;
        cmd.vl     = vl_clamp;
        cmd.rows   = ROWS_W'(vl_round >> LANE_W);  // ceil(vl / lanes)
    end

    // Config register and illegal flag
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            maxvl_q   <= VL_W'(`VMU_LANES * `VMU_VREGS);
            illegal_q <= 1'b0;
        end else begin
            if (accept && instr_i.reconfigure) maxvl_q <= instr_i.maxvl;
            illegal_q <= accept & is_load & ~legal;
        end
    end

    assign illegal_o = illegal_q;

    vmu_fifo #(
        .T (vmu_ld_cmd_t)
    ) u_cmd_q (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (instr_valid_i & is_load & legal),
        .in_i        (cmd),
        .in_ready_o  (instr_ready_o),  // Gates every instruction kind
        .out_valid_o (cmd_valid_o),
        .out_o       (cmd_o),
        .out_ready_i (cmd_ready_i)
    );

endmodule

`default_nettype wire

/* verilog/vmu_ld_eng.sv */
// Vector load engine
// Splits each load into one-element requests and gathers responses per row
`timescale 1ns/100ps
`default_nettype none

`include "vmu_cfg.svh"

module vmu_ld_eng (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    // Decoded load
    input  logic                 cmd_valid_i,
    input  vmu_pkg::vmu_ld_cmd_t cmd_i,
    output logic                 cmd_ready_o,    // Only while idle
    // Memory request / response
    output logic                 req_valid_o,
    output vmu_pkg::mem_req_t    req_o,
    input  logic                 grant_i,
    input  logic                 resp_valid_i,   // No back-pressure
    input  vmu_pkg::mem_resp_t   resp_i,
    // Finished rows
    output logic                 row_valid_o,
    output vmu_pkg::vmu_wb_t     row_o,
    input  logic                 row_ready_i,
    output logic                 busy_o
);
    import vmu_pkg::*;

    //========================================
    // State
    //========================================
    logic                                   busy_q;
    logic [ROWS_W-1:0]                      rows_left_q;  // Rows still to finish, incl. current
    logic [VL_W-1:0]                        vl_left_q;    // Elements from current row onward
    logic [VL_W-1:0]                        vl_next;
    logic [`VMU_LANES-1:0]                  pending_q;    // Lanes still to request
    logic [`VMU_LANES-1:0]                  active_q;     // Lanes in this row
    logic [`VMU_LANES-1:0]                  served_q;     // Lanes with data back
    logic [LANE_W-1:0]                      ptr_q;        // Next lane to request
    mem_op_e                                op_q;
    logic [`VMU_ADDR_W-1:0]                 addr_q;       // Address of next element
    logic [`VMU_ADDR_W-1:0]                 stride_q;
    logic [`VMU_ADDR_W-1:0]                 step;
    logic [REG_W-1:0]                       vreg_q;
    logic [`VMU_LANES-1:0][`VMU_DATA_W-1:0] scratch_q;
    logic                                   cmd_fire;
    logic                                   req_fire;
    logic                                   row_fire;
    logic                                   last_row;

    // Lower n lanes set, all lanes once n reaches a full row
    function automatic logic [`VMU_LANES-1:0] row_mask(input logic [VL_W-1:0] n);
        logic [`VMU_LANES-1:0] mask;
        for (int i = 0; i < `VMU_LANES; i++) begin
            mask[i] = (VL_W'(i) < n);
        end
        return mask;
    endfunction

    // Handshakes
    assign cmd_ready_o = ~busy_q;
    assign busy_o      = busy_q;
    assign cmd_fire    = cmd_valid_i & cmd_ready_o;
    assign req_fire    = req_valid_o & grant_i;
    assign row_fire    = row_valid_o & row_ready_i;

    assign last_row = (rows_left_q == ROWS_W'(1));
    assign vl_next  = vl_left_q - VL_W'(`VMU_LANES);

    //========================================
    // Requests and row output
    //========================================
    assign step        = (op_q == OP_STRIDED) ? stride_q : `VMU_ADDR_W'(4);  // Unit stride 4B
    assign req_valid_o = pending_q[ptr_q];   // Pending lanes are contiguous from lane 0
    assign req_o       = '{addr: addr_q, ticket: ptr_q};

    // Row done once every active lane came back
    assign row_valid_o = (active_q == served_q) & (|active_q);
    assign row_o       = '{vreg: vreg_q, en: active_q, data: scratch_q};

    // Scoreboard
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q      <= 1'b0;
            rows_left_q <= '0;
            vl_left_q   <= '0;
            pending_q   <= '0;
            active_q    <= '0;
            served_q    <= '0;
            ptr_q       <= '0;
        end else if (cmd_fire) begin
            busy_q      <= (cmd_i.rows != '0);   // Empty load leaves engine idle
            rows_left_q <= cmd_i.rows;
            vl_left_q   <= cmd_i.vl;
            pending_q   <= row_mask(cmd_i.vl);
            active_q    <= row_mask(cmd_i.vl);
            served_q    <= '0;
            ptr_q       <= '0;
        end else if (row_fire) begin
            // Next row or back to idle
            rows_left_q <= rows_left_q - 1'b1;
            vl_left_q   <= vl_next;
            pending_q   <= last_row ? '0 : row_mask(vl_next);
            active_q    <= last_row ? '0 : row_mask(vl_next);
            served_q    <= '0;
            ptr_q       <= '0;
            if (last_row) busy_q <= 1'b0;
        end else begin
            if (req_fire) begin
                pending_q[ptr_q] <= 1'b0;
                ptr_q            <= ptr_q + 1'b1;
            end
            if (resp_valid_i) served_q[resp_i.ticket] <= 1'b1;  // Any order
        end
    end

    // Address walk, destination and scratchpad
    always_ff @(posedge clk_i) begin
        if (cmd_fire) begin
            op_q     <= cmd_i.mem_op;
            stride_q <= cmd_i.stride;
            addr_q   <= cmd_i.base;
            vreg_q   <= cmd_i.dst;
        end else begin
            if (req_fire) addr_q <= addr_q + step;   // Carries on across rows
            if (row_fire) vreg_q <= vreg_q + 1'b1;   // Wraps at VMU_VREGS
        end
        if (resp_valid_i) scratch_q[resp_i.ticket] <= resp_i.data;
    end

endmodule

`default_nettype wire

/* verilog/vmu_ld_wb.sv */
// Vector load writeback stage
// Queues rows toward the register file, unlocks a register as its row is written
`timescale 1ns/100ps
`default_nettype none

module vmu_ld_wb (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // Rows from the engine
    input  logic                          row_valid_i,
    input  vmu_pkg::vmu_wb_t              row_i,
    output logic                          row_ready_o,
    // Register file write port
    output logic                          rf_valid_o,
    output vmu_pkg::vmu_wb_t              rf_o,
    input  logic                          rf_ready_i,
    // Register release
    output logic                          unlock_valid_o,
    output logic [vmu_pkg::REG_W-1:0]     unlock_reg_o
);
    import vmu_pkg::*;

    //========================================
    // Row queue
    //========================================
    // Absorbs register file stalls so the engine keeps going
    vmu_fifo #(
        .T (vmu_wb_t)
    ) u_row_q (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (row_valid_i),
        .in_i        (row_i),
        .in_ready_o  (row_ready_o),
        .out_valid_o (rf_valid_o),
        .out_o       (rf_o),
        .out_ready_i (rf_ready_i)
    );

    // Release only on the actual write
    assign unlock_valid_o = rf_valid_o & rf_ready_i;
    assign unlock_reg_o   = rf_o.vreg;

endmodule

`default_nettype wire

/* verilog/vmu_ld_top.sv */
// Vector load subsystem top level
// Decode queue, load engine and writeback queue in a chain
`timescale 1ns/100ps
`default_nettype none

module vmu_ld_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // Instruction port
    input  logic                      instr_valid_i,
    input  vmu_pkg::vmu_instr_t       instr_i,
    output logic                      instr_ready_o,
    // Memory side
    output logic                      req_valid_o,
    output vmu_pkg::mem_req_t         req_o,
    input  logic                      grant_i,
    input  logic                      resp_valid_i,
    input  vmu_pkg::mem_resp_t        resp_i,
    // Register file side
    output logic                      rf_valid_o,
    output vmu_pkg::vmu_wb_t          rf_o,
    input  logic                      rf_ready_i,
    // Status
    output logic                      unlock_valid_o,
    output logic [vmu_pkg::REG_W-1:0] unlock_reg_o,
    output logic                      illegal_o,
    output logic                      busy_o
);
    import vmu_pkg::*;

    logic        cmd_valid;
    logic        cmd_ready;
    vmu_ld_cmd_t cmd;
    logic        row_valid;
    logic        row_ready;
    vmu_wb_t     row;

    //========================================
    // Stages
    //========================================
    vmu_ld_decode u_decode (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .cmd_valid_o   (cmd_valid),
        .cmd_o         (cmd),
        .cmd_ready_i   (cmd_ready),
        .illegal_o     (illegal_o)
    );

    vmu_ld_eng u_eng (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .cmd_ready_o  (cmd_ready),
        .req_valid_o  (req_valid_o),
        .req_o        (req_o),
        .grant_i      (grant_i),
        .resp_valid_i (resp_valid_i),
        .resp_i       (resp_i),
        .row_valid_o  (row_valid),
        .row_o        (row),
        .row_ready_i  (row_ready),
        .busy_o       (busy_o)
    );

    vmu_ld_wb u_wb (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .row_valid_i    (row_valid),
        .row_i          (row),
        .row_ready_o    (row_ready),
        .rf_valid_o     (rf_valid_o),
        .rf_o           (rf_o),
        .rf_ready_i     (rf_ready_i),
        .unlock_valid_o (unlock_valid_o),
        .unlock_reg_o   (unlock_reg_o)
    );

endmodule

`default_nettype wire

/* test/vmu_ld_sva.sv */
// Handshake assertions for the vector load top level
// Bound to every vmu_ld_top instance
`timescale 1ns/100ps
`default_nettype none

module vmu_ld_sva (
    input logic              clk_i,
    input logic              rstn_i,
    input logic              req_valid_o,
    input vmu_pkg::mem_req_t req_o,
    input logic              grant_i,
    input logic              rf_valid_o,
    input vmu_pkg::vmu_wb_t  rf_o,
    input logic              rf_ready_i,
    input logic              unlock_valid_o,
    input logic              busy_o
);

    // Request held through a grant stall
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_o && !grant_i |=> req_valid_o && $stable(req_o))
        else $error("memory request changed while waiting for grant");

    a_rf_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rf_valid_o && !rf_ready_i |=> rf_valid_o && $stable(rf_o))  // RF stall
        else $error("register file row changed while stalled");

    // Unlock only on the actual write
    a_unlock: assert property (@(posedge clk_i) disable iff (!rstn_i)
        unlock_valid_o == (rf_valid_o && rf_ready_i))
        else $error("unlock does not match the register file handshake");

    a_req_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_valid_o && !busy_o))
        else $error("memory request while the engine is idle");

endmodule

bind vmu_ld_top vmu_ld_sva u_sva (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .req_valid_o    (req_valid_o),
    .req_o          (req_o),
    .grant_i        (grant_i),
    .rf_valid_o     (rf_valid_o),
    .rf_o           (rf_o),
    .rf_ready_i     (rf_ready_i),
    .unlock_valid_o (unlock_valid_o),
    .busy_o         (busy_o)
);

`default_nettype wire

/* test/vmu_ld_tb.sv */
// Vector load subsystem testbench
// Directed loads against a shuffling memory model and a stalling register file sink
`timescale 1ns/100ps
`default_nettype none

`include "vmu_cfg.svh"

module vmu_ld_tb;
    import vmu_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;  // All tests together take a few hundred

    logic             clk_i;
    logic             rstn_i;
    logic             instr_valid_i;
    vmu_instr_t       instr_i;
    logic             instr_ready_o;
    logic             req_valid_o;
    mem_req_t         req_o;
    logic             grant_i;
    logic             resp_valid_i;
    mem_resp_t        resp_i;
    logic             rf_valid_o;
    vmu_wb_t          rf_o;
    logic             rf_ready_i;
    logic             unlock_valid_o;
    logic [REG_W-1:0] unlock_reg_o;
    logic             illegal_o;
    logic             busy_o;

    mem_req_t         mem_list[$];  // Granted and not yet answered
    vmu_wb_t          exp_q[$];     // Rows the running test expects
    vmu_wb_t          got_q[$];     // Rows written to the register file
    logic [REG_W-1:0] unl_q[$];     // Unlock register per written row
    logic [31:0]      rng;
    logic             grant_stall;
    logic             rf_stall;
    logic             rf_level;
    int               rf_run;       // Cycles left in this rf_ready_i stretch
    int               cycles;
    int               cur_maxvl;    // Model of the configured maxvl

    vmu_ld_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`VMU_DATA_W-1:0] mem_word(input logic [`VMU_ADDR_W-1:0] addr);
        return addr ^ 32'h5a5a_0000;  // Memory contents rule
    endfunction

    //========================================
    // Failure reporting and compares
    //========================================
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped at cycle %0d", cycles);
    endtask

    task automatic check_wb(input string name, input vmu_wb_t exp, input vmu_wb_t act);
        vmu_wb_t seen;
        seen = act;
        for (int i = 0; i < `VMU_LANES; i++) begin
            if (!exp.en[i]) seen.data[i] = '0;  // Disabled lanes carry stale data
        end
        if (seen !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, seen);
            abort_run();
        end
    endtask

    task automatic check_unlock(input string name, input logic [REG_W-1:0] exp,
                                input logic [REG_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected unlock %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_illegal(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected illegal %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    //========================================
    // Memory model, grant and rf_ready drive
    //========================================
    always @(posedge clk_i) begin : mem_model
        int       idx;
        mem_req_t pick;
        if (rstn_i) begin
            if (req_valid_o && grant_i) mem_list.push_back(req_o);
            rng = xorshift(rng);
            if (mem_list.size() != 0 && rng[0]) begin  // Answer about every other cycle
                idx  = int'(rng[15:8]) % mem_list.size();   // Shuffled order
                pick = mem_list[idx];
                mem_list.delete(idx);
                resp_valid_i <= 1'b1;
                resp_i       <= '{ticket: pick.ticket, data: mem_word(pick.addr)};
            end else begin
                resp_valid_i <= 1'b0;
            end
            grant_i <= grant_stall ? (rng[17:16] != 2'b00) : 1'b1;
            if (rf_run == 0) begin
                rf_level = rng[20];
                rf_run   = int'(rng[23:21]) + 1;  // Stretch of 1 to 8 cycles
            end
            rf_run     = rf_run - 1;
            rf_ready_i <= rf_stall ? rf_level : 1'b1;
        end
    end

    // Register file sink
    always @(posedge clk_i) begin
        if (rstn_i && rf_valid_o && rf_ready_i) begin
            got_q.push_back(rf_o);
            unl_q.push_back(unlock_reg_o);
            if (!unlock_valid_o) begin
                $display("A row was written without its unlock");
                abort_run();
            end
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            abort_run();
        end
    end

    //========================================
    // Stimulus helpers
    //========================================
    task automatic send_instr(input vmu_instr_t ins);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        @(posedge clk_i);
        while (!instr_ready_o) @(posedge clk_i);  // Held until accepted
        instr_valid_i <= 1'b0;
    endtask

    // Expected rows from the load rules
    task automatic expect_load(input logic [REG_W-1:0] dst, input logic [31:0] base,
                               input logic [31:0] step, input int vl);
        vmu_wb_t row;
        int      n;
        int      elem;
        n = (vl < cur_maxvl) ? vl : cur_maxvl;  // Clamp
        for (int r = 0; r < (n + `VMU_LANES - 1) / `VMU_LANES; r++) begin
            row      = '0;
            row.vreg = REG_W'((int'(dst) + r) % `VMU_VREGS);  // Wraps
            for (int i = 0; i < `VMU_LANES; i++) begin
                elem = r * `VMU_LANES + i;
                if (elem < n) begin
                    row.en[i]   = 1'b1;
                    row.data[i] = mem_word(base + step * 32'(elem));
                end
            end
            exp_q.push_back(row);
        end
    endtask

    task automatic send_load(input mem_op_e op, input logic [REG_W-1:0] dst,
                             input logic [31:0] base, input logic [31:0] stride, input int vl);
        vmu_instr_t ins;
        ins        = '0;
        ins.mem_op = op;
        ins.dst    = dst;
        ins.data1  = base;
        ins.data2  = stride;
        ins.vl     = VL_W'(vl);
        send_instr(ins);
        expect_load(dst, base, (op == OP_STRIDED) ? stride : 32'd4, vl);  // Unit stride 4B
    endtask

    task automatic set_maxvl(input int maxvl);
        vmu_instr_t ins;
        ins             = '0;
        ins.reconfigure = 1'b1;
        ins.maxvl       = VL_W'(maxvl);
        send_instr(ins);
        cur_maxvl = maxvl;
    endtask

    // Wait for every expected row and compare in order
    task automatic drain_rows(input string name);
        vmu_wb_t exp;
        @(negedge clk_i);
        while (got_q.size() < exp_q.size()) @(negedge clk_i);  // Sink settled mid-cycle
        while (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            check_wb(name, exp, got_q.pop_front());
            check_unlock(name, exp.vreg, unl_q.pop_front());
        end
        if (busy_o) begin
            $display("%s: busy_o still high after the last row was written", name);
            abort_run();
        end
        @(posedge clk_i);  // Back on a rising edge for the next stimulus
    endtask

    //========================================
    // Directed tests
    //========================================
    task automatic check_reset_state();
        if (!instr_ready_o || req_valid_o || rf_valid_o || unlock_valid_o
            || illegal_o || busy_o) begin
            $display("reset: outputs are not in their reset state");
            abort_run();
        end
    endtask

    task automatic unit_stride_load();
        send_load(OP_UNIT_STRIDED, 3'd2, 32'h100, 32'h0, 8);  // Rows to v2, v3
        drain_rows("unit_stride");
    endtask

    task automatic strided_partial_row();
        send_load(OP_STRIDED, 3'd0, 32'h1000, 32'd12, 5);  // Second row mask 0001
        drain_rows("strided");
    endtask

    task automatic maxvl_clamp();
        set_maxvl(4);
        send_load(OP_UNIT_STRIDED, 3'd6, 32'h400, 32'h0, 12);  // One row only
        drain_rows("maxvl_clamp");
        set_maxvl(`VMU_LANES * `VMU_VREGS);
    endtask

    task automatic grant_stall_loads();
        grant_stall <= 1'b1;
        send_load(OP_UNIT_STRIDED, 3'd5, 32'h2000, 32'h0, 7);
        send_load(OP_STRIDED, 3'd7, 32'h3004, 32'h20, 9);  // Wraps v7, v0, v1
        send_load(OP_UNIT_STRIDED, 3'd0, 32'h40, 32'h0, 3);
        drain_rows("grant_stall");
        grant_stall <= 1'b0;
    endtask

    task automatic rf_backpressure();
        rf_stall <= 1'b1;
        send_load(OP_UNIT_STRIDED, 3'd4, 32'h800, 32'h0, 16);
        send_load(OP_STRIDED, 3'd1, 32'h900, 32'd8, 6);
        drain_rows("rf_stall");
        rf_stall <= 1'b0;
    endtask

    task automatic illegal_op_drop();
        vmu_instr_t ins;
        ins        = '0;
        ins.mem_op = OP_INDEXED;
        ins.dst    = 3'd3;
        ins.data1  = 32'h500;
        ins.data2  = 32'h4;
        ins.vl     = VL_W'(4);
        send_instr(ins);
        @(posedge clk_i);
        check_illegal("illegal_op", 1'b1, illegal_o);  // Cycle after acceptance
        @(posedge clk_i);
        check_illegal("illegal_op", 1'b0, illegal_o);
        repeat (8) @(negedge clk_i);  // Quiet window for a stray row
        if (got_q.size() != 0 || busy_o) begin
            $display("illegal_op: the dropped load still reached the engine");
            abort_run();
        end
        @(posedge clk_i);
        send_load(OP_UNIT_STRIDED, 3'd3, 32'h1234_0000, 32'h0, 4);
        drain_rows("illegal_op");
    endtask

    initial begin
        rstn_i        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        grant_i       = 1'b0;
        resp_valid_i  = 1'b0;
        resp_i        = '0;
        rf_ready_i    = 1'b0;
        rng           = 32'hf25d;
        grant_stall   = 1'b0;
        rf_stall      = 1'b0;
        rf_level      = 1'b1;
        rf_run        = 0;
        cycles        = 0;
        cur_maxvl     = `VMU_LANES * `VMU_VREGS;
        repeat (2) @(posedge clk_i);  // Reset for two cycles
        rstn_i <= 1'b1;
        @(posedge clk_i);
        check_reset_state();
        unit_stride_load();
        strided_partial_row();
        maxvl_clamp();
        grant_stall_loads();
        rf_backpressure();
        illegal_op_drop();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vmu_ld_top.f */
+incdir+include
verilog/vmu_pkg.sv
verilog/vmu_fifo.sv
verilog/vmu_ld_decode.sv
verilog/vmu_ld_eng.sv
verilog/vmu_ld_wb.sv
verilog/vmu_ld_top.sv
test/vmu_ld_sva.sv
test/vmu_ld_tb.sv

/* Makefile */
# Verilator flow for the vector load subsystem
TOP := vmu_ld_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vmu_ld_top.f

obj_dir/V$(TOP): vmu_ld_top.f include/vmu_cfg.svh $(wildcard verilog/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vmu_ld_top.f

# Pass only when the testbench prints its pass line
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
